// File: logic/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] xlen_t;     // data word, operands, program counters
    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] cause_t;    // bit 31 marks an interrupt

    // privilege modes, encoded as in mstatus.mpp
    typedef enum logic [1:0] {
        U = 2'b00,
        M = 2'b11
    } mode_t;

    // low two bits of funct3
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    // machine information registers, read only
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

    // machine trap setup
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;

    // machine trap handling
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MIP       = 12'h344;

    // mxl = 1 (rv32), extensions a, i, m
    localparam xlen_t MISA_VALUE = 32'h4000_1101;

    localparam cause_t CAUSE_M_TIMER = 32'h8000_0007;
    localparam cause_t CAUSE_M_EXT   = 32'h8000_000B;

    // field positions in mstatus
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LO   = 11;

    // field positions shared by mie and mip
    localparam int IRQ_MTI_BIT = 7;
    localparam int IRQ_MEI_BIT = 11;

endpackage

// File: logic/csr_access.sv
`timescale 1ns/1ns

module csr_access (
    input  logic               csr_valid,
    input  csr_pkg::csr_op_t   csr_op,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::xlen_t     csr_src,
    input  logic               csr_src_zero,
    input  csr_pkg::mode_t     current_mode,
    input  csr_pkg::xlen_t     old_value,
    output logic               wr_en,
    output csr_pkg::xlen_t     wr_data,
    output logic               csr_illegal
);
    import csr_pkg::*;

    logic implemented;
    logic write_attempt;
    logic read_only;
    logic priv_fail;

    always_comb
    begin
        case (csr_addr)
            CSR_MISA, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID,
            CSR_MSTATUS, CSR_MIE, CSR_MIP, CSR_MTVEC, CSR_MSCRATCH,
            CSR_MEPC, CSR_MCAUSE, CSR_MTVAL:
                implemented = 1'b1;
            default:
                implemented = 1'b0;
        endcase
    end

    always_comb
    begin
        case (csr_op)
            CSR_RS:  wr_data = old_value | csr_src;
            CSR_RC:  wr_data = old_value & ~csr_src;
            default: wr_data = csr_src;          // plain replace
        endcase
    end

    // rs/rc from x0 only read
    assign write_attempt = (csr_op == CSR_RW) || !csr_src_zero;

    assign read_only = (csr_addr[11:10] == 2'b11);
    assign priv_fail = (csr_addr[9:8] == 2'b11) && (current_mode == U);

    assign csr_illegal = csr_valid &&
                         (!implemented || (read_only && write_attempt) || priv_fail);

    assign wr_en = csr_valid && write_attempt && !csr_illegal;

endmodule

// File: logic/csr_regfile.sv
`timescale 1ns/1ns

module csr_regfile #(
    parameter csr_pkg::xlen_t MTVEC_RESET = 32'h0000_0100,
    parameter csr_pkg::xlen_t HART_ID     = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               nrst,
    input  csr_pkg::csr_addr_t csr_addr,
    input  logic               wr_en,
    input  csr_pkg::xlen_t     wr_data,
    input  logic               trap_taken,
    input  csr_pkg::cause_t    trap_cause,
    input  csr_pkg::xlen_t     trap_value,
    input  csr_pkg::xlen_t     exception_pc,
    input  logic               mret,
    input  logic               irq_m_ext,
    input  logic               irq_m_timer,
    output csr_pkg::xlen_t     csr_rdata,
    output csr_pkg::mode_t     current_mode,
    output logic               mstatus_mie,
    output logic               mie_meie,
    output logic               mie_mtie,
    output csr_pkg::xlen_t     trap_vector,
    output csr_pkg::xlen_t     return_pc
);
    import csr_pkg::*;

    logic        mstatus_mpie;
    mode_t       mstatus_mpp;
    logic [31:2] mtvec_base;                     // direct mode only
    xlen_t       mscratch;
    logic [31:2] mepc_base;
    cause_t      mcause;
    xlen_t       mtval;

    xlen_t mstatus_rd;
    xlen_t mie_rd;
    xlen_t mip_rd;

    // s-mode fields read as zero
    always_comb
    begin
        mstatus_rd = '0;
        mstatus_rd[MSTATUS_MIE_BIT] = mstatus_mie;
        mstatus_rd[MSTATUS_MPIE_BIT] = mstatus_mpie;
        mstatus_rd[MSTATUS_MPP_LO+1:MSTATUS_MPP_LO] = mstatus_mpp;
    end

    always_comb
    begin
        mie_rd = '0;
        mie_rd[IRQ_MTI_BIT] = mie_mtie;
        mie_rd[IRQ_MEI_BIT] = mie_meie;
    end

    // pending bits follow the inputs directly
    always_comb
    begin
        mip_rd = '0;
        mip_rd[IRQ_MTI_BIT] = irq_m_timer;
        mip_rd[IRQ_MEI_BIT] = irq_m_ext;
    end

    always_comb
    begin
        case (csr_addr)
            CSR_MISA:     csr_rdata = MISA_VALUE;
            CSR_MHARTID:  csr_rdata = HART_ID;
            CSR_MSTATUS:  csr_rdata = mstatus_rd;
            CSR_MIE:      csr_rdata = mie_rd;
            CSR_MIP:      csr_rdata = mip_rd;
            CSR_MTVEC:    csr_rdata = {mtvec_base, 2'b00};
            CSR_MSCRATCH: csr_rdata = mscratch;
            CSR_MEPC:     csr_rdata = {mepc_base, 2'b00};
            CSR_MCAUSE:   csr_rdata = mcause;
            CSR_MTVAL:    csr_rdata = mtval;
            default:      csr_rdata = '0;        // vendor, arch, impl ids too
        endcase
    end

    assign trap_vector = {mtvec_base, 2'b00};
    assign return_pc   = {mepc_base, 2'b00};

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            current_mode <= M;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= U;
            mie_meie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mtvec_base   <= MTVEC_RESET[31:2];
            mscratch     <= '0;
            mepc_base    <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end
        else if (trap_taken)
        begin
            // trap entry wins over mret and csr writes
            mepc_base    <= exception_pc[31:2];
            mcause       <= trap_cause;
            mtval        <= trap_value;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= current_mode;
            current_mode <= M;
        end
        else if (mret)
        begin
            current_mode <= mstatus_mpp;
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= U;
        end
        else if (wr_en)
        begin
            case (csr_addr)
                CSR_MSTATUS:
                begin
                    mstatus_mie  <= wr_data[MSTATUS_MIE_BIT];
                    mstatus_mpie <= wr_data[MSTATUS_MPIE_BIT];
                    mstatus_mpp  <= (wr_data[MSTATUS_MPP_LO+1:MSTATUS_MPP_LO] == M) ? M : U;
                end
                CSR_MIE:
                begin
                    mie_mtie <= wr_data[IRQ_MTI_BIT];
                    mie_meie <= wr_data[IRQ_MEI_BIT];
                end
                CSR_MTVEC:    mtvec_base <= wr_data[31:2];
                CSR_MSCRATCH: mscratch   <= wr_data;
                CSR_MEPC:     mepc_base  <= wr_data[31:2];
                CSR_MCAUSE:   mcause     <= wr_data;
                CSR_MTVAL:    mtval      <= wr_data;
                default:      ;                  // misa and mip ignore writes
            endcase
        end
    end

endmodule

// File: logic/trap_ctrl.sv
`timescale 1ns/1ns

module trap_ctrl (
    input  logic            exception_pending,
    input  csr_pkg::cause_t exception_cause,
    input  csr_pkg::xlen_t  exception_tval,
    input  logic            irq_m_ext,
    input  logic            irq_m_timer,
    input  csr_pkg::mode_t  current_mode,
    input  logic            mstatus_mie,
    input  logic            mie_meie,
    input  logic            mie_mtie,
    output logic            trap_taken,
    output csr_pkg::cause_t trap_cause,
    output csr_pkg::xlen_t  trap_value
);
    import csr_pkg::*;

    logic irq_global_en;
    logic ext_fire;
    logic timer_fire;

    // user mode is always interruptible by machine level interrupts
    assign irq_global_en = (current_mode == U) || mstatus_mie;

    assign ext_fire   = irq_m_ext && mie_meie && irq_global_en;
    assign timer_fire = irq_m_timer && mie_mtie && irq_global_en;

    always_comb
    begin
        trap_taken = 1'b0;
        trap_cause = '0;
        trap_value = '0;
        if (exception_pending)
        begin
            trap_taken = 1'b1;
            trap_cause = exception_cause;
            trap_value = exception_tval;
        end
        else if (ext_fire)
        begin
            trap_taken = 1'b1;
            trap_cause = CAUSE_M_EXT;            // external over timer
        end
        else if (timer_fire)
        begin
            trap_taken = 1'b1;
            trap_cause = CAUSE_M_TIMER;
        end
    end

endmodule

// File: logic/csr_unit.sv
`timescale 1ns/1ns

module csr_unit #(
    parameter csr_pkg::xlen_t MTVEC_RESET = 32'h0000_0100,
    parameter csr_pkg::xlen_t HART_ID     = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic               csr_valid,
    input  csr_pkg::csr_op_t   csr_op,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::xlen_t     csr_src,
    input  logic               csr_src_zero,
    input  logic               exception_pending,
    input  csr_pkg::cause_t    exception_cause,
    input  csr_pkg::xlen_t     exception_pc,
    input  csr_pkg::xlen_t     exception_tval,
    input  logic               mret,
    input  logic               irq_m_ext,
    input  logic               irq_m_timer,
    output csr_pkg::xlen_t     csr_rdata,
    output logic               csr_illegal,
    output logic               trap_taken,
    output csr_pkg::xlen_t     trap_vector,
    output csr_pkg::xlen_t     return_pc,
    output csr_pkg::mode_t     current_mode
);
    import csr_pkg::*;

    logic   wr_en;
    xlen_t  wr_data;
    cause_t trap_cause;
    xlen_t  trap_value;
    logic   mstatus_mie;
    logic   mie_meie;
    logic   mie_mtie;

    csr_access u_access (
        .csr_valid    (csr_valid),
        .csr_op       (csr_op),
        .csr_addr     (csr_addr),
        .csr_src      (csr_src),
        .csr_src_zero (csr_src_zero),
        .current_mode (current_mode),
        .old_value    (csr_rdata),               // read-modify-write source
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .csr_illegal  (csr_illegal)
    );

    csr_regfile #(
        .MTVEC_RESET (MTVEC_RESET),
        .HART_ID     (HART_ID)
    ) u_regfile (
        .clk          (clk),
        .nrst         (nrst),
        .csr_addr     (csr_addr),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .trap_taken   (trap_taken),
        .trap_cause   (trap_cause),
        .trap_value   (trap_value),
        .exception_pc (exception_pc),
        .mret         (mret),
        .irq_m_ext    (irq_m_ext),
        .irq_m_timer  (irq_m_timer),
        .csr_rdata    (csr_rdata),
        .current_mode (current_mode),
        .mstatus_mie  (mstatus_mie),
        .mie_meie     (mie_meie),
        .mie_mtie     (mie_mtie),
        .trap_vector  (trap_vector),
        .return_pc    (return_pc)
    );

    trap_ctrl u_trap (
        .exception_pending (exception_pending),
        .exception_cause   (exception_cause),
        .exception_tval    (exception_tval),
        .irq_m_ext         (irq_m_ext),
        .irq_m_timer       (irq_m_timer),
        .current_mode      (current_mode),
        .mstatus_mie       (mstatus_mie),
        .mie_meie          (mie_meie),
        .mie_mtie          (mie_mtie),
        .trap_taken        (trap_taken),
        .trap_cause        (trap_cause),
        .trap_value        (trap_value)
    );

endmodule

// File: bench/csr_unit_assertions.sv
`timescale 1ns/1ns

module csr_unit_assertions (
    input logic               clk,
    input logic               nrst,
    input csr_pkg::csr_addr_t csr_addr,
    input csr_pkg::xlen_t     csr_rdata,
    input logic               csr_illegal,
    input logic               trap_taken,
    input logic               mret,
    input csr_pkg::mode_t     current_mode
);
    import csr_pkg::*;

    int failures = 0;                        // failed assertion count

    a_no_unknown: assert property (@(posedge clk) disable iff (!nrst)
        !$isunknown({trap_taken, csr_illegal}))
        else
        begin
            failures++;
            $error("trap_taken or csr_illegal is unknown");
        end

    a_trap_to_m: assert property (@(posedge clk) disable iff (!nrst)
        trap_taken |=> (current_mode == M))
        else
        begin
            failures++;
            $error("mode after trap entry is not M");
        end

    // an illegal access leaves the addressed register alone
    a_illegal_no_write: assert property (@(posedge clk) disable iff (!nrst)
        (csr_illegal && !trap_taken && !mret && csr_addr != CSR_MIP) ##1 $stable(csr_addr)
        |-> $stable(csr_rdata))
        else
        begin
            failures++;
            $error("illegal access changed the register");
        end

    a_mode_legal: assert property (@(posedge clk)
        (current_mode == M) || (current_mode == U))
        else
        begin
            failures++;
            $error("current_mode holds an undefined encoding");
        end

endmodule

bind csr_unit csr_unit_assertions u_asrt (
    .clk          (clk),
    .nrst         (nrst),
    .csr_addr     (csr_addr),
    .csr_rdata    (csr_rdata),
    .csr_illegal  (csr_illegal),
    .trap_taken   (trap_taken),
    .mret         (mret),
    .current_mode (current_mode)
);

// File: bench/csr_unit_tb.sv
`timescale 1ns/1ns

module csr_unit_tb;
    import csr_pkg::*;

    localparam int MAX_LINES = 200;          // line limit for the file loop

    logic      clk;
    logic      nrst;
    logic      csr_valid;
    csr_op_t   csr_op;
    csr_addr_t csr_addr;
    xlen_t     csr_src;
    logic      csr_src_zero;
    logic      exception_pending;
    cause_t    exception_cause;
    xlen_t     exception_pc;
    xlen_t     exception_tval;
    logic      mret;
    logic      irq_m_ext;
    logic      irq_m_timer;
    xlen_t     csr_rdata;
    logic      csr_illegal;
    logic      trap_taken;
    xlen_t     trap_vector;
    xlen_t     return_pc;
    mode_t     current_mode;

    reg [8*512-1:0] line;
    reg [8*32-1:0]  test_name;
    logic [31:0]    in_val [0:11];           // valid, op, addr, src ... irq_timer
    logic [31:0]    exp_val [0:5];           // rdata, illegal, trap, vector, ret_pc, mode
    int fd;
    int got;
    int line_count;
    int vectors;
    int errors;
    int total;

    csr_unit u_dut (
        .clk               (clk),
        .nrst              (nrst),
        .csr_valid         (csr_valid),
        .csr_op            (csr_op),
        .csr_addr          (csr_addr),
        .csr_src           (csr_src),
        .csr_src_zero      (csr_src_zero),
        .exception_pending (exception_pending),
        .exception_cause   (exception_cause),
        .exception_pc      (exception_pc),
        .exception_tval    (exception_tval),
        .mret              (mret),
        .irq_m_ext         (irq_m_ext),
        .irq_m_timer       (irq_m_timer),
        .csr_rdata         (csr_rdata),
        .csr_illegal       (csr_illegal),
        .trap_taken        (trap_taken),
        .trap_vector       (trap_vector),
        .return_pc         (return_pc),
        .current_mode      (current_mode)
    );

    always #50 clk = ~clk;

    task automatic apply_inputs();
        csr_valid         = in_val[0][0];
        csr_op            = csr_op_t'(in_val[1][1:0]);
        csr_addr          = in_val[2][11:0];
        csr_src           = in_val[3];
        csr_src_zero      = in_val[4][0];
        exception_pending = in_val[5][0];
        exception_cause   = in_val[6];
        exception_pc      = in_val[7];
        exception_tval    = in_val[8];
        mret              = in_val[9][0];
        irq_m_ext         = in_val[10][0];
        irq_m_timer       = in_val[11][0];
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("** Error %0s %0s: expected %h, actual %h", test_name, what, expected, actual);
    endtask

    task automatic check_outputs();
        if (csr_rdata !== exp_val[0]) report_mismatch("csr_rdata", exp_val[0], csr_rdata);
        if (csr_illegal !== exp_val[1][0])
            report_mismatch("csr_illegal", exp_val[1], {31'b0, csr_illegal});
        if (trap_taken !== exp_val[2][0])
            report_mismatch("trap_taken", exp_val[2], {31'b0, trap_taken});
        if (trap_vector !== exp_val[3]) report_mismatch("trap_vector", exp_val[3], trap_vector);
        if (return_pc !== exp_val[4]) report_mismatch("return_pc", exp_val[4], return_pc);
        if (current_mode !== exp_val[5][1:0])
            report_mismatch("current_mode", exp_val[5], {30'b0, current_mode});
    endtask

    initial
    begin
        clk = 1'b0;
        nrst = 1'b0;
        csr_valid = 1'b0;
        csr_op = CSR_RW;
        csr_addr = '0;
        csr_src = '0;
        csr_src_zero = 1'b0;
        exception_pending = 1'b0;
        exception_cause = '0;
        exception_pc = '0;
        exception_tval = '0;
        mret = 1'b0;
        irq_m_ext = 1'b0;
        irq_m_timer = 1'b0;
        errors = 0;
        vectors = 0;
        line_count = 0;
        repeat (2) @(posedge clk);
        #10;
        nrst = 1'b1;
        fd = $fopen("bench/csr_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file bench/csr_stimulus.txt");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && line_count < MAX_LINES)
            begin
                line = '0;
                got = $fgets(line, fd);
                line_count++;
                got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              test_name, in_val[0], in_val[1], in_val[2], in_val[3],
                              in_val[4], in_val[5], in_val[6], in_val[7], in_val[8],
                              in_val[9], in_val[10], in_val[11], exp_val[0], exp_val[1],
                              exp_val[2], exp_val[3], exp_val[4], exp_val[5]);
                if (got == 19)                   // comment and blank lines skipped
                begin
                    @(posedge clk);
                    #10;
                    apply_inputs();
                    #80;                         // just before the next edge
                    check_outputs();
                    vectors++;
                end
            end
            if (!$feof(fd))
            begin
                $display("stimulus file is longer than %0d lines, run stopped", MAX_LINES);
                errors++;
            end
            $fclose(fd);
            if (vectors == 0)
            begin
                $display("the stimulus file holds no test vectors");
                errors++;
            end
        end
        total = errors + u_dut.u_asrt.failures;
        $display("vectors: %0d, errors: %0d, assertion failures: %0d",
                 vectors, errors, u_dut.u_asrt.failures);
        if (total == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: bench/csr_stimulus.txt
# name valid op addr src src_zero exc_pending exc_cause exc_pc exc_tval mret irq_ext irq_timer
# then expected rdata illegal trap_taken trap_vector return_pc mode, all hex
rst_mstatus 0 1 300 0 0 0 0 0 0 0 0 0 0 0 0 100 0 3
rst_mie 0 1 304 0 0 0 0 0 0 0 0 0 0 0 0 100 0 3
rst_mtvec 0 1 305 0 0 0 0 0 0 0 0 0 100 0 0 100 0 3
rst_mscratch 0 1 340 0 0 0 0 0 0 0 0 0 0 0 0 100 0 3
rst_mepc 0 1 341 0 0 0 0 0 0 0 0 0 0 0 0 100 0 3
rst_mcause 0 1 342 0 0 0 0 0 0 0 0 0 0 0 0 100 0 3
rst_mtval 0 1 343 0 0 0 0 0 0 0 0 0 0 0 0 100 0 3
rst_mhartid 0 1 f14 0 0 0 0 0 0 0 0 0 0 0 0 100 0 3
rst_misa 0 1 301 0 0 0 0 0 0 0 0 0 40001101 0 0 100 0 3
rw_mscratch 1 1 340 12345678 0 0 0 0 0 0 0 0 0 0 0 100 0 3
rs_mscratch 1 2 340 0000f000 0 0 0 0 0 0 0 0 12345678 0 0 100 0 3
rc_mscratch 1 3 340 00000678 0 0 0 0 0 0 0 0 1234f678 0 0 100 0 3
rs_x0 1 2 340 ffffffff 1 0 0 0 0 0 0 0 1234f000 0 0 100 0 3
rc_x0 1 3 340 ffffffff 1 0 0 0 0 0 0 0 1234f000 0 0 100 0 3
wr_mstatus 1 1 300 ffffffff 0 0 0 0 0 0 0 0 0 0 0 100 0 3
wr_mpp_01 1 1 300 00000880 0 0 0 0 0 0 0 0 1888 0 0 100 0 3
wr_mie 1 1 304 ffffffff 0 0 0 0 0 0 0 0 0 0 0 100 0 3
wr_mepc 1 1 341 00002003 0 0 0 0 0 0 0 0 0 0 0 100 0 3
wr_mtvec 1 1 305 00000203 0 0 0 0 0 0 0 0 100 0 0 100 2000 3
ill_addr 1 1 7c0 00000001 0 0 0 0 0 0 0 0 0 1 0 200 2000 3
ill_hartid 1 1 f14 00000005 0 0 0 0 0 0 0 0 0 1 0 200 2000 3
rd_hartid 1 2 f14 0 1 0 0 0 0 0 0 0 0 0 0 200 2000 3
mret_to_u 0 1 300 0 0 0 0 0 0 1 0 0 80 0 0 200 2000 3
rd_mstatus_u 0 1 300 0 0 0 0 0 0 0 0 0 88 0 0 200 2000 0
ill_user 1 2 340 0 1 0 0 0 0 0 0 0 1234f000 1 0 200 2000 0
exc_user 0 1 300 0 0 1 00000002 00003006 deadbeef 0 0 0 88 0 1 200 2000 0
rd_mcause 0 1 342 0 0 0 0 0 0 0 0 0 2 0 0 200 3004 3
rd_mtval 0 1 343 0 0 0 0 0 0 0 0 0 deadbeef 0 0 200 3004 3
rd_mstatus_trap 0 1 300 0 0 0 0 0 0 0 0 0 80 0 0 200 3004 3
exc_and_write 1 1 340 aaaaaaaa 0 1 00000005 00004000 00000123 0 0 0 1234f000 0 1 200 3004 3
rd_mscratch 0 1 340 0 0 0 0 0 0 0 0 0 1234f000 0 0 200 4000 3
en_mtie 1 1 304 00000080 0 0 0 0 0 0 0 0 880 0 0 200 4000 3
tmr_masked 0 1 344 0 0 0 0 0 0 0 0 1 80 0 0 200 4000 3
set_mie 1 2 300 00000008 0 0 0 0 0 0 0 1 1800 0 0 200 4000 3
tmr_trap 0 1 342 0 0 0 0 00005008 0 0 0 1 5 0 1 200 4000 3
rd_mcause_tmr 0 1 342 0 0 0 0 0 0 0 0 0 80000007 0 0 200 5008 3
en_both 1 1 304 00000880 0 0 0 0 0 0 0 0 80 0 0 200 5008 3
set_mie2 1 2 300 00000008 0 0 0 0 0 0 0 0 1880 0 0 200 5008 3
both_irq 0 1 344 0 0 0 0 00006000 0 0 1 1 880 0 1 200 5008 3
rd_mcause_ext 0 1 342 0 0 0 0 0 0 0 0 0 8000000b 0 0 200 6000 3
set_mpp_u 1 1 300 0 0 0 0 0 0 0 0 0 1880 0 0 200 6000 3
mret_u2 0 1 300 0 0 0 0 0 0 1 0 0 0 0 0 200 6000 3
tmr_user 0 1 300 0 0 0 0 00007004 0 0 0 1 80 0 1 200 6000 0
rd_after_user 0 1 342 0 0 0 0 0 0 0 0 0 80000007 0 0 200 7004 3

// File: verilog.f
logic/csr_pkg.sv
logic/csr_access.sv
logic/csr_regfile.sv
logic/trap_ctrl.sv
logic/csr_unit.sv
bench/csr_unit_assertions.sv
bench/csr_unit_tb.sv
